/* compile.f */
+incdir+logic
logic/pix_pkg.sv
logic/apb_pkg.sv
logic/apb_slave.sv
logic/window_store.sv
logic/block_sequencer.sv
logic/median_block.sv
logic/result_store.sv
logic/denoise_top.sv
tb/tb_clk_gen.sv
tb/tb_denoise.sv

/* logic/apb_pkg.sv */
`include "denoise_consts.svh"

package apb_pkg;

    typedef logic [`APB_ADDR_W-1:0] paddr_t;
    typedef logic [`APB_DATA_W-1:0] pdata_t;

endpackage

/* logic/apb_slave.sv */
`timescale 1ns/1ns
`include "denoise_consts.svh"

module apb_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  apb_pkg::paddr_t   paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  apb_pkg::pdata_t   pwdata,
    output apb_pkg::pdata_t   prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              busy,
    input  logic              done,
    input  pix_pkg::pixel_t   pix_rdata,
    input  pix_pkg::pixel_t   res_rdata,
    output logic              pix_we,
    output pix_pkg::pix_idx_t pix_waddr,
    output pix_pkg::pixel_t   pix_wdata,
    output pix_pkg::pix_idx_t pix_raddr,
    output pix_pkg::res_idx_t res_raddr,
    output logic              start
);
    apb_pkg::paddr_t pix_off;
    apb_pkg::paddr_t res_off;
    apb_pkg::pdata_t rd_mux;
    logic            pix_hit;
    logic            res_hit;
    logic            ctrl_hit;
    logic            stat_hit;
    logic            setup;
    logic            access;

    // byte lanes ignored, one word per pixel or result
    assign pix_off  = paddr - `ADDR_PIX_BASE;
    assign res_off  = paddr - `ADDR_RES_BASE;
    assign pix_hit  = pix_off < 12'(4 * `NUM_PIX);
    assign res_hit  = (paddr >= `ADDR_RES_BASE) && (res_off < 12'(4 * `NUM_RES));
    assign ctrl_hit = (paddr == `ADDR_CTRL);
    assign stat_hit = (paddr == `ADDR_STATUS);

    assign setup  = psel & ~penable;
    assign access = psel & penable;

    assign pix_waddr = pix_off[8:2];
    assign pix_raddr = pix_off[8:2];
    assign pix_wdata = pwdata[`PIX_W-1:0];
    assign res_raddr = res_off[7:2];

    assign pix_we  = access & pwrite & pix_hit & ~busy;     // dropped while running
    assign start   = access & pwrite & ctrl_hit & pwdata[0] & ~busy;
    assign pready  = 1'b1;
    assign pslverr = access & (~(pix_hit | res_hit | ctrl_hit | stat_hit)
                               | (pwrite & pix_hit & busy));

    always_comb begin
        rd_mux = '0;
        if (pix_hit)
            rd_mux[`PIX_W-1:0] = pix_rdata;
        else if (res_hit)
            rd_mux[`PIX_W-1:0] = res_rdata;
        else if (stat_hit)
            rd_mux[1:0] = {busy, done};
    end

    // sampled in the setup phase so it is stable through the access phase
    always_ff @(posedge clk) begin
        if (!rst_n)
            prdata <= '0;
        else if (setup && !pwrite)
            prdata <= rd_mux;
    end

    // an accepted start freezes the strip from the next cycle on
    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> busy);

endmodule

/* logic/block_sequencer.sv */
`timescale 1ns/1ns
`include "denoise_consts.svh"

module block_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    output logic              busy,
    output logic              issue_valid,
    output pix_pkg::blk_idx_t issue_blk
);
    pix_pkg::seq_state_t state;
    pix_pkg::blk_idx_t   blk_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= pix_pkg::SEQ_IDLE;
            blk_cnt <= '0;
        end else begin
            case (state)
                pix_pkg::SEQ_IDLE: begin
                    blk_cnt <= '0;
                    if (start)
                        state <= pix_pkg::SEQ_ISSUE;
                end
                pix_pkg::SEQ_ISSUE: begin
                    blk_cnt <= blk_cnt + 1'b1;   // wraps back to 0 after block 3
                    if (blk_cnt == pix_pkg::blk_idx_t'(`NUM_BLOCKS - 1))
                        state <= pix_pkg::SEQ_IDLE;
                end
                default: state <= pix_pkg::SEQ_IDLE;
            endcase
        end
    end

    // one block per cycle while issuing
    assign busy        = (state == pix_pkg::SEQ_ISSUE);
    assign issue_valid = (state == pix_pkg::SEQ_ISSUE);
    assign issue_blk   = blk_cnt;

    a_blk_order: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && $past(issue_valid) |-> issue_blk == $past(issue_blk) + 2'd1);

    // every run opens with block 0 right after a start
    a_run_open: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(issue_valid) |-> $past(start) && issue_blk == '0);

endmodule

/* logic/denoise_consts.svh */
`ifndef DENOISE_CONSTS_SVH
`define DENOISE_CONSTS_SVH

// strip geometry
`define WIN_ROWS      5
`define WIN_COLS      14
`define NUM_PIX       70     // WIN_ROWS * WIN_COLS

// block tiling
`define BLK_SIZE      5
`define OUT_SIZE      3
`define NUM_BLOCKS    4
`define BLOCK_STRIDE  3      // window column step from one block to the next
`define NUM_RES       36     // NUM_BLOCKS * OUT_SIZE * OUT_SIZE

// widths behind the package types
`define PIX_W         8
`define PIX_IDX_W     7
`define RES_IDX_W     6
`define BLK_IDX_W     2

`define APB_ADDR_W    12
`define APB_DATA_W    32

// apb address map in bytes
`define ADDR_PIX_BASE 12'h000  // pixel i at base + 4i
`define ADDR_CTRL     12'h200  // start request in bit 0
`define ADDR_STATUS   12'h204  // done in bit 0 and busy in bit 1
`define ADDR_RES_BASE 12'h300  // result k at base + 4k

`endif

/* logic/denoise_top.sv */
`timescale 1ns/1ns
`include "denoise_consts.svh"

module denoise_top (
    input  logic            clk,
    input  logic            rst_n,
    input  apb_pkg::paddr_t paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apb_pkg::pdata_t pwdata,
    output apb_pkg::pdata_t prdata,
    output logic            pready,
    output logic            pslverr
);
    logic              pix_we;
    pix_pkg::pix_idx_t pix_waddr;
    pix_pkg::pixel_t   pix_wdata;
    pix_pkg::pix_idx_t pix_raddr;
    pix_pkg::pixel_t   pix_rdata;
    pix_pkg::res_idx_t res_raddr;
    pix_pkg::pixel_t   res_rdata;
    logic              start;
    logic              busy;
    logic              done;
    logic              issue_valid;
    pix_pkg::blk_idx_t issue_blk;
    pix_pkg::pixel_t   blk_pix [`BLK_SIZE*`BLK_SIZE];
    logic              out_valid;
    pix_pkg::blk_idx_t out_blk;
    pix_pkg::pixel_t   out_pix [`OUT_SIZE*`OUT_SIZE];

    apb_slave u_apb (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .busy(busy), .done(done), .pix_rdata(pix_rdata), .res_rdata(res_rdata),
        .pix_we(pix_we), .pix_waddr(pix_waddr), .pix_wdata(pix_wdata),
        .pix_raddr(pix_raddr), .res_raddr(res_raddr), .start(start)
    );

    window_store u_win (
        .clk(clk), .rst_n(rst_n),
        .pix_we(pix_we), .pix_waddr(pix_waddr), .pix_wdata(pix_wdata),
        .pix_raddr(pix_raddr), .pix_rdata(pix_rdata),
        .issue_blk(issue_blk), .blk_pix(blk_pix)
    );

    block_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start(start),
        .busy(busy), .issue_valid(issue_valid), .issue_blk(issue_blk)
    );

    median_block u_med (
        .clk(clk), .rst_n(rst_n),
        .in_valid(issue_valid), .in_blk(issue_blk), .in_pix(blk_pix),
        .out_valid(out_valid), .out_blk(out_blk), .out_pix(out_pix)
    );

    result_store u_res (
        .clk(clk), .rst_n(rst_n), .start(start),
        .out_valid(out_valid), .out_blk(out_blk), .out_pix(out_pix),
        .res_raddr(res_raddr), .res_rdata(res_rdata), .done(done)
    );

endmodule

/* logic/median_block.sv */
`timescale 1ns/1ns
`include "denoise_consts.svh"

module median_block (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  pix_pkg::blk_idx_t in_blk,
    input  pix_pkg::pixel_t   in_pix [`BLK_SIZE*`BLK_SIZE],
    output logic              out_valid,
    output pix_pkg::blk_idx_t out_blk,
    output pix_pkg::pixel_t   out_pix [`OUT_SIZE*`OUT_SIZE]
);
    localparam int NUM_ROW_MED = `BLK_SIZE * `OUT_SIZE;   // 5 rows by 3 positions

    pix_pkg::pixel_t   row_med [NUM_ROW_MED];   // index 3*row + col
    logic              s1_valid;
    pix_pkg::blk_idx_t s1_blk;

    function automatic pix_pkg::pixel_t med3(input pix_pkg::pixel_t a,
                                             input pix_pkg::pixel_t b,
                                             input pix_pkg::pixel_t c);
        pix_pkg::pixel_t lo;
        pix_pkg::pixel_t hi;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        // c outside [lo, hi] clamps to the nearer bound
        if (c >= hi)
            return hi;
        else if (c <= lo)
            return lo;
        else
            return c;
    endfunction

    // stage 1: horizontal medians, each shared by up to three outputs
    always_ff @(posedge clk) begin
        for (int r = 0; r < `BLK_SIZE; r++) begin
            for (int c = 0; c < `OUT_SIZE; c++) begin
                row_med[r*`OUT_SIZE + c] <= med3(in_pix[r*`BLK_SIZE + c],
                                                 in_pix[r*`BLK_SIZE + c + 1],
                                                 in_pix[r*`BLK_SIZE + c + 2]);
            end
        end
    end

    // stage 2: vertical median over rows r..r+2
    always_ff @(posedge clk) begin
        for (int r = 0; r < `OUT_SIZE; r++) begin
            for (int c = 0; c < `OUT_SIZE; c++) begin
                out_pix[r*`OUT_SIZE + c] <= med3(row_med[r*`OUT_SIZE + c],
                                                 row_med[(r+1)*`OUT_SIZE + c],
                                                 row_med[(r+2)*`OUT_SIZE + c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // block tag rides along with the data
    always_ff @(posedge clk) begin
        s1_blk  <= in_blk;
        out_blk <= s1_blk;
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##2 (out_valid && out_blk == $past(in_blk, 2)));

endmodule

/* logic/pix_pkg.sv */
`include "denoise_consts.svh"

package pix_pkg;

    typedef logic [`PIX_W-1:0]     pixel_t;
    typedef logic [`PIX_IDX_W-1:0] pix_idx_t;   // 0..69 in the strip
    typedef logic [`RES_IDX_W-1:0] res_idx_t;   // 0..35 in the result buffer
    typedef logic [`BLK_IDX_W-1:0] blk_idx_t;

    // block issue FSM
    typedef enum logic {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

endpackage

/* logic/result_store.sv */
`timescale 1ns/1ns
`include "denoise_consts.svh"

module result_store (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              out_valid,
    input  pix_pkg::blk_idx_t out_blk,
    input  pix_pkg::pixel_t   out_pix [`OUT_SIZE*`OUT_SIZE],
    input  pix_pkg::res_idx_t res_raddr,
    output pix_pkg::pixel_t   res_rdata,
    output logic              done
);
    localparam int BLK_RES = `OUT_SIZE * `OUT_SIZE;   // results per block

    pix_pkg::pixel_t   res_mem [`NUM_RES];
    pix_pkg::res_idx_t wr_base;

    assign wr_base = pix_pkg::res_idx_t'(out_blk) * pix_pkg::res_idx_t'(BLK_RES);

    // a whole block lands in one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_RES; i++)
                res_mem[i] <= '0;
        end else if (out_valid) begin
            for (int i = 0; i < BLK_RES; i++)
                res_mem[wr_base + i] <= out_pix[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            done <= 1'b0;
        else if (start)
            done <= 1'b0;
        else if (out_valid && out_blk == pix_pkg::blk_idx_t'(`NUM_BLOCKS - 1))
            done <= 1'b1;   // last block written
    end

    assign res_rdata = (res_raddr < `NUM_RES) ? res_mem[res_raddr] : '0;

endmodule

/* logic/window_store.sv */
`timescale 1ns/1ns
`include "denoise_consts.svh"

module window_store (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pix_we,
    input  pix_pkg::pix_idx_t pix_waddr,
    input  pix_pkg::pixel_t   pix_wdata,
    input  pix_pkg::pix_idx_t pix_raddr,
    output pix_pkg::pixel_t   pix_rdata,
    input  pix_pkg::blk_idx_t issue_blk,
    output pix_pkg::pixel_t   blk_pix [`BLK_SIZE*`BLK_SIZE]
);
    pix_pkg::pixel_t   strip [`NUM_PIX];   // row-major, index row*14 + col
    pix_pkg::pix_idx_t col0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_PIX; i++)
                strip[i] <= '0;
        end else if (pix_we) begin
            strip[pix_waddr] <= pix_wdata;
        end
    end

    assign pix_rdata = (pix_raddr < `NUM_PIX) ? strip[pix_raddr] : '0;

    // left window column of the selected block
    assign col0 = pix_pkg::pix_idx_t'(issue_blk) * pix_pkg::pix_idx_t'(`BLOCK_STRIDE);

    always_comb begin
        for (int r = 0; r < `BLK_SIZE; r++) begin
            for (int c = 0; c < `BLK_SIZE; c++) begin
                blk_pix[r*`BLK_SIZE + c] = strip[r*`WIN_COLS + col0 + c];
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the denoiser testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_denoise -Mdir obj_dir -o tb_denoise
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_denoise > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD = 20;   // 40 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;   // released off the edge like the other inputs
    end

endmodule

/* tb/tb_denoise.sv */
`timescale 1ns/1ns
`include "denoise_consts.svh"

module tb_denoise;
    // five runs of roughly 110 transfers at 3 cycles each, plus margin
    localparam int MAX_CYCLES = 6000;

    logic            clk;
    logic            rst_n;
    apb_pkg::paddr_t paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    apb_pkg::pdata_t pwdata;
    apb_pkg::pdata_t prdata;
    logic            pready;
    logic            pslverr;

    int              errors = 0;
    int              checks = 0;
    int              cycles = 0;
    logic [31:0]     lfsr;
    logic [7:0]      img [`NUM_PIX];          // expected strip contents
    logic [7:0]      expect_res [`NUM_RES];
    apb_pkg::pdata_t rd_data;                 // prdata seen in the access phase
    logic            rd_err;                  // pslverr seen in the access phase

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    denoise_top DUT (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic rand_byte(output logic [7:0] v);
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};   // one step per bit
        end
    endtask

    // median as sum minus the two extremes
    function automatic int med3(input int a, input int b, input int c);
        int hi;
        int lo;
        hi = (a > b) ? a : b;
        hi = (hi > c) ? hi : c;
        lo = (a < b) ? a : b;
        lo = (lo < c) ? lo : c;
        return a + b + c - hi - lo;
    endfunction

    task automatic build_model();
        int rm [3];
        int base;
        for (int b = 0; b < `NUM_BLOCKS; b++) begin
            for (int r = 0; r < `OUT_SIZE; r++) begin
                for (int c = 0; c < `OUT_SIZE; c++) begin
                    for (int j = 0; j < 3; j++) begin
                        base = (r + j) * `WIN_COLS + b * `BLOCK_STRIDE + c;
                        rm[j] = med3(img[base], img[base + 1], img[base + 2]);
                    end
                    expect_res[9*b + 3*r + c] = 8'(med3(rm[0], rm[1], rm[2]));
                end
            end
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    // setup, access, then one idle cycle
    task automatic apb_xfer(input logic wr, input apb_pkg::paddr_t addr,
                            input apb_pkg::pdata_t data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);   // middle of the access phase
        rd_data = prdata;
        rd_err  = pslverr;
        check_val($sformatf("pready at 0x%0h", addr), 1, pready);
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_pkg::paddr_t addr, input apb_pkg::pdata_t data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input apb_pkg::paddr_t addr);
        apb_xfer(1'b0, addr, '0);
    endtask

    task automatic load_image();
        for (int i = 0; i < `NUM_PIX; i++) begin
            apb_write(`ADDR_PIX_BASE + 12'(4 * i), {24'h0, img[i]});
            check_val($sformatf("pslverr on pixel write %0d", i), 0, rd_err);
        end
    endtask

    task automatic wait_done(output bit saw_busy);
        saw_busy = 0;
        do begin
            apb_read(`ADDR_STATUS);
            if (rd_data[1])
                saw_busy = 1;
        end while (!rd_data[0]);
    endtask

    task automatic check_results();
        build_model();
        for (int k = 0; k < `NUM_RES; k++) begin
            apb_read(`ADDR_RES_BASE + 12'(4 * k));
            check_val($sformatf("prdata result %0d", k), {24'h0, expect_res[k]}, rd_data);
        end
    endtask

    task automatic check_flat(input logic [7:0] level);
        for (int k = 0; k < `NUM_RES; k++) begin
            apb_read(`ADDR_RES_BASE + 12'(4 * k));
            check_val($sformatf("prdata result %0d", k), {24'h0, level}, rd_data);
        end
    endtask

    task automatic reset_values();
        apb_read(`ADDR_STATUS);
        check_val("prdata status", 0, rd_data);
        apb_read(`ADDR_RES_BASE);
        check_val("prdata result 0", 0, rd_data);
        apb_read(`ADDR_PIX_BASE);
        check_val("prdata pixel 0", 0, rd_data);
    endtask

    task automatic constant_image();
        bit saw_busy;
        for (int i = 0; i < `NUM_PIX; i++)
            img[i] = 8'h5a;
        load_image();
        apb_write(`ADDR_CTRL, 32'h1);
        wait_done(saw_busy);
        if (!saw_busy) begin
            errors++;
            $display("busy was never seen high before done");
        end
        check_flat(8'h5a);
    endtask

    task automatic random_image();
        bit saw_busy;
        for (int i = 0; i < `NUM_PIX; i++)
            rand_byte(img[i]);
        load_image();
        apb_write(`ADDR_CTRL, 32'h1);
        wait_done(saw_busy);
        check_results();
    endtask

    task automatic impulse_image();
        bit saw_busy;
        for (int i = 0; i < `NUM_PIX; i++)
            img[i] = 8'h10;
        img[0*`WIN_COLS + 1]  = 8'hff;   // one spike per row, far apart
        img[1*`WIN_COLS + 12] = 8'hff;
        img[2*`WIN_COLS + 5]  = 8'hff;
        img[3*`WIN_COLS + 3]  = 8'hff;
        img[4*`WIN_COLS + 9]  = 8'hff;
        load_image();
        apb_write(`ADDR_CTRL, 32'h1);
        wait_done(saw_busy);
        check_flat(8'h10);
    endtask

    task automatic error_responses_and_restart();
        bit saw_busy;
        apb_read(12'h1f0);
        check_val("pslverr on unmapped read 0x1f0", 1, rd_err);
        apb_read(12'h3a0);
        check_val("pslverr on unmapped read 0x3a0", 1, rd_err);

        // pixel write lands while the blocks are being issued
        apb_write(`ADDR_CTRL, 32'h1);
        apb_write(`ADDR_PIX_BASE + 12'(4 * 20), 32'hee);
        check_val("pslverr on pixel write while busy", 1, rd_err);
        wait_done(saw_busy);
        apb_read(`ADDR_PIX_BASE + 12'(4 * 20));
        check_val("prdata pixel 20", {24'h0, img[20]}, rd_data);
        check_results();

        for (int i = 0; i < `NUM_PIX; i++)
            rand_byte(img[i]);
        load_image();
        apb_write(`ADDR_CTRL, 32'h1);
        apb_read(`ADDR_STATUS);
        check_val("prdata status done bit after restart", 0, rd_data[0]);
        wait_done(saw_busy);
        check_results();
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 32'h9be7;
        wait (rst_n === 1'b1);

        reset_values();
        constant_image();
        random_image();
        impulse_image();
        error_responses_and_restart();

        $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
